//--- filelist.f
hdl/scalePkg.sv
hdl/enabledShiftRegister.sv
hdl/coeffRegs.sv
hdl/mulStage.sv
hdl/roundStage.sv
hdl/scalePipe.sv
test/scalePipe_assertions.sv
test/scalePipeTb.sv

//--- hdl/coeffRegs.sv
`default_nettype none

module coeffRegs (
    input  wire logic                              clk,
    input  wire logic                              rst,
    // Write address and data
    input  wire logic [scalePkg::AXI_ADDR_W-1:0]   awaddr,
    input  wire logic                              awvalid,
    output logic                                   awready,
    input  wire logic [scalePkg::AXI_DATA_W-1:0]   wdata,
    input  wire logic                              wvalid,
    output logic                                   wready,
    // Write response
    output logic      [1:0]                        bresp,
    output logic                                   bvalid,
    input  wire logic                              bready,
    // Read address and data
    input  wire logic [scalePkg::AXI_ADDR_W-1:0]   araddr,
    input  wire logic                              arvalid,
    output logic                                   arready,
    output logic      [scalePkg::AXI_DATA_W-1:0]   rdata,
    output logic      [1:0]                        rresp,
    output logic                                   rvalid,
    input  wire logic                              rready,
    // Configuration to the data path
    output logic      [scalePkg::COEF_W-1:0]       coef,
    output logic      [scalePkg::PROD_W-1:0]       offset,
    output logic      [scalePkg::SHIFT_W-1:0]      shift
);

    import scalePkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic                  wrEn;
    logic                  rdEn;
    logic [AXI_DATA_W-1:0] readWord;

    // Address and data are taken together, one write at a time
    assign wrEn = awvalid && wvalid && !bvalid;
    assign rdEn = arvalid && !rvalid;

    assign awready = wrEn;
    assign wready = wrEn;
    assign arready = rdEn;

    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            coef <= COEF_RESET;
            offset <= '0;
            shift <= '0;
        end else if (wrEn) begin
            // Unmapped addresses fall through and are still answered
            case (awaddr)
                ADDR_COEF: coef <= wdata[COEF_W-1:0];
                ADDR_OFFSET: offset <= wdata[PROD_W-1:0];
                ADDR_SHIFT: shift <= wdata[SHIFT_W-1:0];
                default: ;
            endcase
        end
    end

    // Write response channel
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wrEn) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_comb begin
        case (araddr)
            ADDR_COEF: readWord = {{(AXI_DATA_W-COEF_W){1'b0}}, coef};
            ADDR_OFFSET: readWord = offset;
            ADDR_SHIFT: readWord = {{(AXI_DATA_W-SHIFT_W){1'b0}}, shift};
            default: readWord = '0;
        endcase
    end

    // Read data channel, data held until the master takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rdEn) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdata <= readWord;
        end
    end

endmodule

`default_nettype wire

//--- hdl/enabledShiftRegister.sv
`default_nettype none

module enabledShiftRegister #(
    parameter int CYCLES = 1,
    parameter int WIDTH = 1,
    parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             clkEn,
    input  wire logic [WIDTH-1:0] din,
    output logic      [WIDTH-1:0] dout
);

    generate
        if (CYCLES == 0) begin : genWire
            assign dout = din;
        end else begin : genChain
            logic [WIDTH-1:0] stages [CYCLES];

            // Whole chain moves one step per enabled cycle
            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int i = 0; i < CYCLES; i++) begin
                        stages[i] <= RESET_VALUE;
                    end
                end else if (clkEn) begin
                    stages[0] <= din;
                    for (int i = 1; i < CYCLES; i++) begin
                        stages[i] <= stages[i-1];
                    end
                end
            end

            assign dout = stages[CYCLES-1];
        end
    endgenerate

endmodule

`default_nettype wire

//--- hdl/mulStage.sv
`default_nettype none

module mulStage #(
    parameter int MUL_CYCLES = 3
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire logic                                 advance,
    input  wire logic                                 inValid,
    input  wire logic signed [scalePkg::SAMPLE_W-1:0] sample,
    input  wire logic signed [scalePkg::COEF_W-1:0]   coef,
    input  wire logic signed [scalePkg::PROD_W-1:0]   offset,
    input  wire logic        [scalePkg::SHIFT_W-1:0]  shift,
    output logic                                      outValid,
    output logic signed      [scalePkg::PROD_W-1:0]   product,
    output logic signed      [scalePkg::PROD_W-1:0]   offsetOut,
    output logic             [scalePkg::SHIFT_W-1:0]  shiftOut
);

    import scalePkg::*;

    logic                             validQ;
    logic signed [SAMPLE_W-1:0]       sampleQ;
    logic signed [COEF_W-1:0]         coefQ;
    logic signed [PROD_W-1:0]         offsetQ;
    logic        [SHIFT_W-1:0]        shiftQ;
    logic signed [PROD_W-1:0]         productNow;
    logic        [PROD_W+SHIFT_W-1:0] sideOut;

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
        end else if (advance) begin
            validQ <= inValid;
        end
    end

    // Configuration is sampled together with the sample it applies to
    always_ff @(posedge clk) begin
        if (advance) begin
            sampleQ <= sample;
            coefQ <= coef;
            offsetQ <= offset;
            shiftQ <= shift;
        end
    end

    assign productNow = sampleQ * coefQ;

    // Registers after the multiplier, free for retiming into it
    enabledShiftRegister #(.CYCLES(MUL_CYCLES), .WIDTH(PROD_W)) productDelay (
        .clk(clk), .rst(rst), .clkEn(advance), .din(productNow), .dout(product)
    );

    enabledShiftRegister #(.CYCLES(MUL_CYCLES), .WIDTH(1), .RESET_VALUE(1'b0)) validDelay (
        .clk(clk), .rst(rst), .clkEn(advance), .din(validQ), .dout(outValid)
    );

    // Offset and shift ride alongside the product
    enabledShiftRegister #(.CYCLES(MUL_CYCLES), .WIDTH(PROD_W + SHIFT_W)) sideDelay (
        .clk(clk), .rst(rst), .clkEn(advance), .din({offsetQ, shiftQ}), .dout(sideOut)
    );

    assign offsetOut = sideOut[PROD_W+SHIFT_W-1:SHIFT_W];
    assign shiftOut = sideOut[SHIFT_W-1:0];

endmodule

`default_nettype wire

//--- hdl/roundStage.sv
`default_nettype none

module roundStage (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire logic                                 inValid,
    input  wire logic signed [scalePkg::PROD_W-1:0]   product,
    input  wire logic signed [scalePkg::PROD_W-1:0]   offset,
    input  wire logic        [scalePkg::SHIFT_W-1:0]  shift,
    input  wire logic                                 outReady,
    output logic                                      advance,
    output logic                                      outValid,
    output logic signed      [scalePkg::SAMPLE_W-1:0] result
);

    import scalePkg::*;

    localparam logic signed [PROD_W-1:0] SAT_MAX = PROD_W'(2 ** (SAMPLE_W - 1) - 1);
    localparam logic signed [PROD_W-1:0] SAT_MIN = -PROD_W'(2 ** (SAMPLE_W - 1));

    logic signed [PROD_W-1:0]   sum;
    logic signed [PROD_W-1:0]   halfLsb;
    logic signed [PROD_W-1:0]   shifted;
    logic signed [SAMPLE_W-1:0] saturated;

    always_comb begin
        sum = product + offset;
        // Round half up, no rounding term for a zero shift
        halfLsb = '0;
        if (shift != '0) begin
            halfLsb = PROD_W'(1) << (shift - 1'b1);
        end
        shifted = (sum + halfLsb) >>> shift;
        if (shifted > SAT_MAX) begin
            saturated = SAT_MAX[SAMPLE_W-1:0];
        end else if (shifted < SAT_MIN) begin
            saturated = SAT_MIN[SAMPLE_W-1:0];
        end else begin
            saturated = shifted[SAMPLE_W-1:0];
        end
    end

    // Single stall point for the whole pipeline
    assign advance = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (advance) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            result <= saturated;
        end
    end

endmodule

`default_nettype wire

//--- hdl/scalePipe.sv
`default_nettype none

module scalePipe #(
    parameter int MUL_CYCLES = 3
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    // AXI4-Lite configuration slave
    input  wire logic [scalePkg::AXI_ADDR_W-1:0]      awaddr,
    input  wire logic                                 awvalid,
    output logic                                      awready,
    input  wire logic [scalePkg::AXI_DATA_W-1:0]      wdata,
    input  wire logic                                 wvalid,
    output logic                                      wready,
    output logic      [1:0]                           bresp,
    output logic                                      bvalid,
    input  wire logic                                 bready,
    input  wire logic [scalePkg::AXI_ADDR_W-1:0]      araddr,
    input  wire logic                                 arvalid,
    output logic                                      arready,
    output logic      [scalePkg::AXI_DATA_W-1:0]      rdata,
    output logic      [1:0]                           rresp,
    output logic                                      rvalid,
    input  wire logic                                 rready,
    // Sample stream
    input  wire logic                                 inValid,
    input  wire logic signed [scalePkg::SAMPLE_W-1:0] inData,
    output logic                                      inReady,
    output logic                                      outValid,
    output logic signed      [scalePkg::SAMPLE_W-1:0] outData,
    input  wire logic                                 outReady
);

    import scalePkg::*;

    logic signed [COEF_W-1:0]  coef;
    logic signed [PROD_W-1:0]  offset;
    logic        [SHIFT_W-1:0] shift;
    logic                      advance;
    logic                      mulValid;
    logic signed [PROD_W-1:0]  product;
    logic signed [PROD_W-1:0]  mulOffset;
    logic        [SHIFT_W-1:0] mulShift;

    coeffRegs u_regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .coef(coef), .offset(offset), .shift(shift)
    );

    mulStage #(.MUL_CYCLES(MUL_CYCLES)) u_mul (
        .clk(clk), .rst(rst), .advance(advance),
        .inValid(inValid), .sample(inData),
        .coef(coef), .offset(offset), .shift(shift),
        .outValid(mulValid), .product(product),
        .offsetOut(mulOffset), .shiftOut(mulShift)
    );

    roundStage u_round (
        .clk(clk), .rst(rst),
        .inValid(mulValid), .product(product), .offset(mulOffset), .shift(mulShift),
        .outReady(outReady), .advance(advance),
        .outValid(outValid), .result(outData)
    );

    // Input is ready whenever the pipeline moves
    assign inReady = advance;

endmodule

`default_nettype wire

//--- hdl/scalePkg.sv
`default_nettype none

package scalePkg;

    // Stream and arithmetic widths
    localparam int SAMPLE_W = 16;
    localparam int COEF_W = 16;
    localparam int PROD_W = 32;
    localparam int SHIFT_W = 4;

    // Configuration bus
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    // Register map, byte addresses
    localparam logic [AXI_ADDR_W-1:0] ADDR_COEF = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] ADDR_OFFSET = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] ADDR_SHIFT = 4'h8;

    // Unity gain so the pipeline passes samples through after reset
    localparam logic [COEF_W-1:0] COEF_RESET = 16'd1;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module scalePipeTb -f filelist.f \
    || { echo "Build failed"; exit 1; }
simOut=$(./obj_dir/VscalePipeTb 2>&1)
echo "$simOut"
echo "$simOut" | grep -qx "PASS: all tests" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- test/scalePipeTb.sv
`default_nettype none

module scalePipeTb;
    timeunit 1ns;
    timeprecision 100ps;

    import scalePkg::*;

    localparam int MUL_CYCLES = 3;
    localparam int TIMEOUT = 100;
    localparam int SAMPLE_MAX = 2 ** (SAMPLE_W - 1) - 1;
    localparam int SAMPLE_MIN = -(2 ** (SAMPLE_W - 1));

    logic                       clk;
    logic                       rst;
    logic [AXI_ADDR_W-1:0]      awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [AXI_DATA_W-1:0]      wdata;
    logic                       wvalid;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready;
    logic [AXI_ADDR_W-1:0]      araddr;
    logic                       arvalid;
    logic                       arready;
    logic [AXI_DATA_W-1:0]      rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rready;
    logic                       inValid;
    logic signed [SAMPLE_W-1:0] inData;
    logic                       inReady;
    logic                       outValid;
    logic signed [SAMPLE_W-1:0] outData;
    logic                       outReady;

    // Register values as the model sees them
    logic signed [COEF_W-1:0]   coefMirror;
    logic signed [PROD_W-1:0]   offsetMirror;
    logic        [SHIFT_W-1:0]  shiftMirror;
    logic signed [SAMPLE_W-1:0] expected [$];
    logic [31:0]                lfsrState;
    int                         errCount;

    scalePipe #(.MUL_CYCLES(MUL_CYCLES)) u_dut (.*);

    bind scalePipe scalePipeAssertions u_assert (
        .clk(clk), .rst(rst), .outValid(outValid), .outData(outData), .outReady(outReady),
        .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rdata(rdata), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // Multiply, add offset in 32 bits, round half up, shift, saturate
    function automatic logic signed [SAMPLE_W-1:0] expectScaled(
        input logic signed [SAMPLE_W-1:0] s
    );
        int acc;
        int sh;
        sh = int'(shiftMirror);
        acc = int'(s) * int'(coefMirror) + int'(offsetMirror);
        if (sh > 0) acc = acc + (1 << (sh - 1));
        acc = acc >>> sh;
        if (acc > SAMPLE_MAX) return SAMPLE_W'(SAMPLE_MAX);
        if (acc < SAMPLE_MIN) return SAMPLE_W'(SAMPLE_MIN);
        return SAMPLE_W'(acc);
    endfunction

    task automatic abortRun();
        errCount++;
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic waitFailed(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        abortRun();
    endtask

    task automatic checkSample(input logic signed [SAMPLE_W-1:0] got,
                               input logic signed [SAMPLE_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic checkReg(input logic [AXI_DATA_W-1:0] got,
                            input logic [AXI_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic axiWrite(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data);
        int n;
        @(negedge clk);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        n = 0;
        #1;
        while (!(awready && wready)) begin
            n++;
            if (n > TIMEOUT) waitFailed("awready and wready");
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        n = 0;
        while (!bvalid) begin
            n++;
            if (n > TIMEOUT) waitFailed("bvalid");
            @(negedge clk);
        end
        checkReg(AXI_DATA_W'(bresp), '0, "bresp");
        // Response left waiting for a few cycles
        repeat (randBits(2)) @(negedge clk);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data);
        int n;
        @(negedge clk);
        araddr = addr;
        arvalid = 1'b1;
        n = 0;
        #1;
        while (!arready) begin
            n++;
            if (n > TIMEOUT) waitFailed("arready");
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            n++;
            if (n > TIMEOUT) waitFailed("rvalid");
            @(negedge clk);
        end
        data = rdata;
        checkReg(AXI_DATA_W'(rresp), '0, "rresp");
        // Read data left waiting for a few cycles
        repeat (randBits(2)) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic checkMirrors();
        logic [AXI_DATA_W-1:0] got;
        axiRead(ADDR_COEF, got);
        checkReg(got, {{(AXI_DATA_W-COEF_W){1'b0}}, coefMirror}, "coef read");
        axiRead(ADDR_OFFSET, got);
        checkReg(got, offsetMirror, "offset read");
        axiRead(ADDR_SHIFT, got);
        checkReg(got, {{(AXI_DATA_W-SHIFT_W){1'b0}}, shiftMirror}, "shift read");
    endtask

    task automatic configure(input logic [AXI_DATA_W-1:0] c, input logic [AXI_DATA_W-1:0] o,
                             input logic [AXI_DATA_W-1:0] s);
        axiWrite(ADDR_COEF, c);
        axiWrite(ADDR_OFFSET, o);
        axiWrite(ADDR_SHIFT, s);
        // Only the low bits of the coefficient and shift words are held
        coefMirror = c[COEF_W-1:0];
        offsetMirror = o;
        shiftMirror = s[SHIFT_W-1:0];
        checkMirrors();
    endtask

    // One clock of stream traffic, transfers happen at the next rising edge
    task automatic streamCycle(input logic v, input logic signed [SAMPLE_W-1:0] d,
                               input logic rdy);
        @(negedge clk);
        inValid = v;
        inData = d;
        outReady = rdy;
        #1;
        if (inValid && inReady) begin
            expected.push_back(expectScaled(inData));
        end
        if (outValid && outReady) begin
            if (expected.size() == 0) begin
                $display("Output at %0t ns with no sample outstanding", $time);
                abortRun();
            end
            checkSample(outData, expected.pop_front(), "outData");
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (expected.size() != 0) begin
            n++;
            if (n > TIMEOUT) waitFailed("the pipeline to drain");
            streamCycle(1'b0, '0, 1'b1);
        end
    endtask

    initial begin
        logic [AXI_DATA_W-1:0] word;
        int                    lat;
        lfsrState = 32'd73828;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        inValid = 1'b0;
        inData = '0;
        outReady = 1'b0;
        errCount = 0;
        coefMirror = COEF_RESET;
        offsetMirror = '0;
        shiftMirror = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset values give an identity pipeline
        checkMirrors();
        for (int i = 0; i < 16; i++) streamCycle(1'b1, SAMPLE_W'(randBits(SAMPLE_W)), 1'b1);
        drain();

        // Full random words, then the unmapped address
        for (int i = 0; i < 4; i++) configure(randBits(32), randBits(32), randBits(32));
        axiWrite(4'hC, randBits(32));
        axiRead(4'hC, word);
        checkReg(word, '0, "unmapped read");
        checkMirrors();

        // Offsets of varied magnitude, many of them saturate
        for (int round = 0; round < 40; round++) begin
            word = randBits(32);
            configure(randBits(32), AXI_DATA_W'($signed(word) >>> randBits(5)), randBits(32));
            for (int i = 0; i < 16; i++) begin
                streamCycle(1'b1, SAMPLE_W'(randBits(SAMPLE_W)), 1'b1);
            end
            drain();
        end

        // Random back-pressure
        for (int i = 0; i < 400; i++) begin
            streamCycle(randBits(1), SAMPLE_W'(randBits(SAMPLE_W)), randBits(1));
        end
        drain();
        // No stray or repeated result once every sample is out
        for (int i = 0; i < MUL_CYCLES + 2; i++) streamCycle(1'b0, '0, 1'b1);

        // Single sample through an idle pipeline, counted in register stages
        streamCycle(1'b1, SAMPLE_W'(randBits(SAMPLE_W)), 1'b1);
        checkCount(expected.size(), 1, "samples accepted");
        lat = 0;
        while (expected.size() != 0) begin
            lat++;
            if (lat > TIMEOUT) waitFailed("the single sample");
            streamCycle(1'b0, '0, 1'b1);
        end
        checkCount(lat, MUL_CYCLES + 2, "latency");

        if (errCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/scalePipe_assertions.sv
`default_nettype none

module scalePipeAssertions (
    input wire logic                            clk,
    input wire logic                            rst,
    input wire logic                            outValid,
    input wire logic [scalePkg::SAMPLE_W-1:0]   outData,
    input wire logic                            outReady,
    input wire logic                            bvalid,
    input wire logic                            bready,
    input wire logic                            rvalid,
    input wire logic [scalePkg::AXI_DATA_W-1:0] rdata,
    input wire logic                            rready
);
    timeunit 1ns;
    timeprecision 100ps;

    // Stalled output word stays put
    assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(outData))
        else $error("outValid or outData changed while outReady was low");

    assert property (@(posedge clk) rst |=> !outValid)
        else $error("outValid high during reset");

    assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid or rdata changed before rready");

endmodule

`default_nettype wire
